// File: hw/rtc_pkg.sv
`default_nettype none

package rtc_pkg;

    ////////////////////////////////////////////////////////////
    // Time representation
    ////////////////////////////////////////////////////////////

    // Number of BCD digits in hh:mm:ss
    localparam int NUM_DIGITS = 6;

    // One BCD digit
    typedef logic [3:0] bcd_t;

    // Six digits, hour tens in the top nibble, second units at the bottom
    typedef logic [23:0] time_bcd_t;

    ////////////////////////////////////////////////////////////
    // Display
    ////////////////////////////////////////////////////////////

    // Segments a..g, a in bit 6, active high
    typedef logic [6:0] seg_t;

    // One-hot digit enable, bit 5 is hour tens
    typedef logic [5:0] digit_sel_t;

    ////////////////////////////////////////////////////////////
    // Host port FSM
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        SET_IDLE,
        SET_ACK
    } set_state_t;

endpackage : rtc_pkg

`default_nettype wire

// File: hw/rtc_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_tick_gen #(
    parameter int CLK_DIV = 20_000_000
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);

    logic [CNT_W-1:0] cnt;
    logic             cnt_wrap;

    assign cnt_wrap = (cnt == CNT_LAST);

    // Free-running cycle counter, one full lap per second
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt_wrap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Registered so the first pulse lands CLK_DIV cycles after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick <= 1'b0;
        end else begin
            tick <= cnt_wrap;
        end
    end

endmodule : rtc_tick_gen

`default_nettype wire

// File: hw/rtc_time_counter.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_time_counter import rtc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run,
    input  logic      tick,
    input  logic      time_load,
    input  time_bcd_t load_value,
    output time_bcd_t time_now
);

    bcd_t hr_t;
    bcd_t hr_u;
    bcd_t min_t;
    bcd_t min_u;
    bcd_t sec_t;
    bcd_t sec_u;

    logic step;
    logic carry_sec_t;
    logic carry_min_u;
    logic carry_min_t;
    logic carry_hr_u;
    logic day_wrap;

    ////////////////////////////////////////////////////////////
    // Carry chain
    ////////////////////////////////////////////////////////////

    assign step = tick & run;

    // Each carry needs every lower digit at its top value
    assign carry_sec_t = step & (sec_u == 4'd9);
    assign carry_min_u = carry_sec_t & (sec_t == 4'd5);
    assign carry_min_t = carry_min_u & (min_u == 4'd9);
    assign carry_hr_u  = carry_min_t & (min_t == 4'd5);

    // 23:59:59 rolls to 00:00:00
    assign day_wrap = carry_hr_u & (hr_t == 4'd2) & (hr_u == 4'd3);

    ////////////////////////////////////////////////////////////
    // Digit registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hr_t  <= '0;
            hr_u  <= '0;
            min_t <= '0;
            min_u <= '0;
            sec_t <= '0;
            sec_u <= '0;
        end else if (time_load) begin
            // Load beats a tick on the same edge
            hr_t  <= load_value[23:20];
            hr_u  <= load_value[19:16];
            min_t <= load_value[15:12];
            min_u <= load_value[11:8];
            sec_t <= load_value[7:4];
            sec_u <= load_value[3:0];
        end else if (step) begin
            sec_u <= (sec_u == 4'd9) ? 4'd0 : sec_u + 4'd1;

            if (carry_sec_t) begin
                sec_t <= (sec_t == 4'd5) ? 4'd0 : sec_t + 4'd1;
            end

            if (carry_min_u) begin
                min_u <= (min_u == 4'd9) ? 4'd0 : min_u + 4'd1;
            end

            if (carry_min_t) begin
                min_t <= (min_t == 4'd5) ? 4'd0 : min_t + 4'd1;
            end

            // Hours wrap at 23 instead of 99
            if (day_wrap) begin
                hr_u <= 4'd0;
                hr_t <= 4'd0;
            end else if (carry_hr_u) begin
                if (hr_u == 4'd9) begin
                    hr_u <= 4'd0;
                    hr_t <= hr_t + 4'd1;
                end else begin
                    hr_u <= hr_u + 4'd1;
                end
            end
        end
    end

    assign time_now = {hr_t, hr_u, min_t, min_u, sec_t, sec_u};

endmodule : rtc_time_counter

`default_nettype wire

// File: hw/rtc_set_port.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_set_port import rtc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      set_req,
    input  logic      set_sel,
    input  time_bcd_t set_data,
    output logic      set_ack,
    output logic      set_err,
    output logic      time_load,
    output logic      alarm_load,
    output time_bcd_t load_value
);

    set_state_t state;
    logic       accept;
    logic       data_ok;

    // Legal 24-hour BCD time
    function automatic logic time_legal(input time_bcd_t v);
        logic digits_ok;
        logic hours_ok;
        logic tens_ok;
        digits_ok = (v[23:20] <= 4'd9) && (v[19:16] <= 4'd9) &&
                    (v[15:12] <= 4'd9) && (v[11:8] <= 4'd9) &&
                    (v[7:4] <= 4'd9) && (v[3:0] <= 4'd9);
        hours_ok  = (v[23:20] < 4'd2) || ((v[23:20] == 4'd2) && (v[19:16] <= 4'd3));
        tens_ok   = (v[15:12] <= 4'd5) && (v[7:4] <= 4'd5);
        return digits_ok && hours_ok && tens_ok;
    endfunction

    assign data_ok = time_legal(set_data);

    // New request seen in idle
    assign accept = (state == SET_IDLE) && set_req;

    // Load fires on the same edge that raises set_ack
    assign time_load  = accept && data_ok && !set_sel;
    assign alarm_load = accept && data_ok && set_sel;
    assign load_value = set_data;

    assign set_ack = (state == SET_ACK);

    ////////////////////////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SET_IDLE;
            set_err <= 1'b0;
        end else begin
            case (state)
                SET_IDLE: begin
                    if (set_req) begin
                        state   <= SET_ACK;
                        set_err <= !data_ok;
                    end
                end
                SET_ACK: begin
                    // Hold ack until the host drops its request
                    if (!set_req) begin
                        state   <= SET_IDLE;
                        set_err <= 1'b0;
                    end
                end
                default: begin
                    state   <= SET_IDLE;
                    set_err <= 1'b0;
                end
            endcase
        end
    end

endmodule : rtc_set_port

`default_nettype wire

// File: hw/rtc_alarm.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_alarm import rtc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      alarm_load,
    input  time_bcd_t load_value,
    input  time_bcd_t time_now,
    input  logic      alarm_en,
    input  logic      alarm_clr,
    output logic      alarm_flag
);

    time_bcd_t alarm_val;
    logic      match;
    logic      match_q;

    assign match = (time_now == alarm_val);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alarm_val <= '0;
        end else if (alarm_load) begin
            alarm_val <= load_value;
        end
    end

    // Time and alarm both come out of reset at 00:00:00, so that match is old
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match_q <= 1'b1;
        end else begin
            match_q <= match;
        end
    end

    ////////////////////////////////////////////////////////////
    // Sticky flag, set on a fresh match only
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alarm_flag <= 1'b0;
        end else if (alarm_clr) begin
            alarm_flag <= 1'b0;
        end else if (alarm_en && match && !match_q) begin
            alarm_flag <= 1'b1;
        end
    end

endmodule : rtc_alarm

`default_nettype wire

// File: hw/rtc_display_scan.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_display_scan import rtc_pkg::*; #(
    parameter int SCAN_DIV = 50_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  time_bcd_t  time_now,
    output digit_sel_t digit_sel,
    output seg_t       seg
);

    localparam int DWELL_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(SCAN_DIV - 1);
    localparam int DIGIT_W = $bits(bcd_t);

    logic [DWELL_W-1:0] dwell;
    logic               dwell_wrap;
    bcd_t               digit;

    ////////////////////////////////////////////////////////////
    // Scan timing
    ////////////////////////////////////////////////////////////

    assign dwell_wrap = (dwell == DWELL_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwell <= '0;
        end else if (dwell_wrap) begin
            dwell <= '0;
        end else begin
            dwell <= dwell + 1'b1;
        end
    end

    // Walk from hour tens down to second units, then back to the top
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit_sel <= digit_sel_t'(1) << (NUM_DIGITS - 1);
        end else if (dwell_wrap) begin
            digit_sel <= {digit_sel[0], digit_sel[NUM_DIGITS-1:1]};
        end
    end

    ////////////////////////////////////////////////////////////
    // Digit mux and decoder
    ////////////////////////////////////////////////////////////

    always_comb begin
        digit = '0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (digit_sel[i]) begin
                digit = time_now[i*DIGIT_W +: DIGIT_W];
            end
        end
    end

    // Patterns are abcdefg
    always_comb begin
        case (digit)
            4'd0:    seg = 7'b1111110;
            4'd1:    seg = 7'b0110000;
            4'd2:    seg = 7'b1101101;
            4'd3:    seg = 7'b1111001;
            4'd4:    seg = 7'b0110011;
            4'd5:    seg = 7'b1011011;
            4'd6:    seg = 7'b1011111;
            4'd7:    seg = 7'b1110000;
            4'd8:    seg = 7'b1111111;
            4'd9:    seg = 7'b1111011;
            default: seg = 7'b0000000;
        endcase
    end

endmodule : rtc_display_scan

`default_nettype wire

// File: hw/rtc_top.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_top import rtc_pkg::*; #(
    parameter int CLK_DIV  = 20_000_000,
    parameter int SCAN_DIV = 50_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  logic       set_req,
    input  logic       set_sel,
    input  time_bcd_t  set_data,
    output logic       set_ack,
    output logic       set_err,
    input  logic       alarm_en,
    input  logic       alarm_clr,
    output time_bcd_t  time_now,
    output logic       alarm_flag,
    output digit_sel_t digit_sel,
    output seg_t       seg
);

    logic      tick;
    logic      time_load;
    logic      alarm_load;
    time_bcd_t load_value;

    ////////////////////////////////////////////////////////////
    // Timebase and counter
    ////////////////////////////////////////////////////////////

    rtc_tick_gen #(
        .CLK_DIV (CLK_DIV)
    ) u_tick_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    rtc_time_counter u_time_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .tick       (tick),
        .time_load  (time_load),
        .load_value (load_value),
        .time_now   (time_now)
    );

    ////////////////////////////////////////////////////////////
    // Host port, alarm and display
    ////////////////////////////////////////////////////////////

    rtc_set_port u_set_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .set_req    (set_req),
        .set_sel    (set_sel),
        .set_data   (set_data),
        .set_ack    (set_ack),
        .set_err    (set_err),
        .time_load  (time_load),
        .alarm_load (alarm_load),
        .load_value (load_value)
    );

    rtc_alarm u_alarm (
        .clk        (clk),
        .rst_n      (rst_n),
        .alarm_load (alarm_load),
        .load_value (load_value),
        .time_now   (time_now),
        .alarm_en   (alarm_en),
        .alarm_clr  (alarm_clr),
        .alarm_flag (alarm_flag)
    );

    rtc_display_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) u_display_scan (
        .clk       (clk),
        .rst_n     (rst_n),
        .time_now  (time_now),
        .digit_sel (digit_sel),
        .seg       (seg)
    );

endmodule : rtc_top

`default_nettype wire

// File: verification/rtc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_tb import rtc_pkg::*;;

    localparam int CLK_DIV      = 8;
    localparam int SCAN_DIV     = 3;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int ACK_LIMIT    = 16;
    // Rough length of each test in seconds from reset to display
    localparam int TEST_SECONDS = 1 + 10 + 8 + 6 + 10 + 4;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       run;
    logic       set_req;
    logic       set_sel;
    time_bcd_t  set_data;
    logic       set_ack;
    logic       set_err;
    logic       alarm_en;
    logic       alarm_clr;
    time_bcd_t  time_now;
    logic       alarm_flag;
    digit_sel_t digit_sel;
    seg_t       seg;
    string      test_name;

    rtc_top #(
        .CLK_DIV  (CLK_DIV),
        .SCAN_DIV (SCAN_DIV)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .set_req    (set_req),
        .set_sel    (set_sel),
        .set_data   (set_data),
        .set_ack    (set_ack),
        .set_err    (set_err),
        .alarm_en   (alarm_en),
        .alarm_clr  (alarm_clr),
        .time_now   (time_now),
        .alarm_flag (alarm_flag),
        .digit_sel  (digit_sel),
        .seg        (seg)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic int to_seconds(input time_bcd_t t);
        int h;
        int m;
        int s;
        h = int'(t[23:20]) * 10 + int'(t[19:16]);
        m = int'(t[15:12]) * 10 + int'(t[11:8]);
        s = int'(t[7:4]) * 10 + int'(t[3:0]);
        return h * 3600 + m * 60 + s;
    endfunction

    function automatic time_bcd_t from_seconds(input int secs);
        int h;
        int m;
        int s;
        h = secs / 3600;
        m = (secs / 60) % 60;
        s = secs % 60;
        return {bcd_t'(h / 10), bcd_t'(h % 10), bcd_t'(m / 10), bcd_t'(m % 10),
                bcd_t'(s / 10), bcd_t'(s % 10)};
    endfunction

    function automatic time_bcd_t next_second(input time_bcd_t t);
        return from_seconds((to_seconds(t) + 1) % 86400);
    endfunction

    // Standard abcdefg patterns with blank above 9
    function automatic seg_t seg_pattern(input bcd_t d);
        seg_t table_q [10] = '{7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33,
                               7'h5B, 7'h5F, 7'h70, 7'h7F, 7'h7B};
        if (d > 4'd9) begin
            return 7'h00;
        end
        return table_q[d];
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks and host helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_time(input time_bcd_t exp, input time_bcd_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", test_name, exp, act));
        end
    endtask

    task automatic check_bit(input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b", test_name, exp, act));
        end
    endtask

    task automatic check_seg(input seg_t exp, input seg_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b", test_name, exp, act));
        end
    endtask

    task automatic check_sel(input digit_sel_t exp, input digit_sel_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b", test_name, exp, act));
        end
    endtask

    // Full four-phase write that returns what was visible while set_ack was high
    task automatic host_write(input logic sel, input time_bcd_t data,
                              output time_bcd_t time_seen, output logic err_seen);
        int waited;
        @(negedge clk);
        set_req  = 1'b1;
        set_sel  = sel;
        set_data = data;
        waited   = 0;
        while (set_ack !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                abort_run($sformatf("%s: set_ack never rose after set_req", test_name));
            end
        end
        time_seen = time_now;
        err_seen  = set_err;
        set_req   = 1'b0;
        waited    = 0;
        while (set_ack !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                abort_run($sformatf("%s: set_ack stayed high after set_req fell", test_name));
            end
        end
    endtask

    task automatic wait_time_change(input time_bcd_t prev, output time_bcd_t seen);
        int waited;
        waited = 0;
        while (time_now === prev) begin
            @(negedge clk);
            waited++;
            if (waited > 2 * CLK_DIV) begin
                abort_run($sformatf("%s: time_now did not advance within two seconds",
                                    test_name));
            end
        end
        seen = time_now;
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        test_name = "reset";
        check_time(24'h000000, time_now);
        check_bit(1'b0, set_ack);
        check_bit(1'b0, set_err);
        check_bit(1'b0, alarm_flag);
        check_sel(6'b100000, digit_sel);
    endtask

    task automatic test_counting();
        time_bcd_t prev;
        time_bcd_t cur;
        test_name = "counting";
        @(negedge clk);
        run  = 1'b1;
        prev = time_now;
        repeat (5) begin
            wait_time_change(prev, cur);
            check_time(next_second(prev), cur);
            prev = cur;
        end
        run = 1'b0;
        // Ticks keep coming but the digits hold
        repeat (3 * CLK_DIV) begin
            @(negedge clk);
            check_time(prev, time_now);
        end
    endtask

    task automatic test_rollover();
        time_bcd_t starts [3] = '{24'h095958, 24'h195958, 24'h235958};
        time_bcd_t prev;
        time_bcd_t cur;
        logic      err;
        test_name = "rollover";
        foreach (starts[i]) begin
            @(negedge clk);
            run = 1'b1;
            host_write(1'b0, starts[i], prev, err);
            check_bit(1'b0, err);
            check_time(starts[i], prev);
            repeat (2) begin
                wait_time_change(prev, cur);
                check_time(next_second(prev), cur);
                prev = cur;
            end
        end
        @(negedge clk);
        run = 1'b0;
    endtask

    task automatic test_set_port();
        time_bcd_t bad_values [4] = '{24'h240000, 24'h126000, 24'h12345A, 24'h156012};
        time_bcd_t value;
        time_bcd_t seen;
        logic      err;
        test_name = "set_port";
        repeat (4) begin
            value = from_seconds(int'($urandom % 86400));
            host_write(1'b0, value, seen, err);
            check_bit(1'b0, err);
            check_time(value, seen);
        end
        foreach (bad_values[i]) begin
            host_write(1'b0, bad_values[i], seen, err);
            check_bit(1'b1, err);
            check_time(value, seen);
            check_time(value, time_now);
        end
    endtask

    task automatic test_alarm();
        time_bcd_t seen;
        time_bcd_t cur;
        logic      err;
        test_name = "alarm";
        host_write(1'b0, 24'h000003, seen, err);
        host_write(1'b1, 24'h000005, seen, err);
        check_bit(1'b0, err);
        @(negedge clk);
        alarm_en = 1'b1;
        @(negedge clk);
        check_bit(1'b0, alarm_flag);
        run = 1'b1;
        wait_time_change(24'h000003, cur);
        check_time(24'h000004, cur);
        check_bit(1'b0, alarm_flag);
        wait_time_change(cur, cur);
        check_time(24'h000005, cur);
        // Flag follows the match by one cycle
        check_bit(1'b0, alarm_flag);
        @(negedge clk);
        check_bit(1'b1, alarm_flag);
        alarm_clr = 1'b1;
        @(negedge clk);
        alarm_clr = 1'b0;
        check_bit(1'b0, alarm_flag);
        @(negedge clk);
        check_bit(1'b0, alarm_flag);

        // Same match again with the alarm disabled
        run      = 1'b0;
        alarm_en = 1'b0;
        host_write(1'b0, 24'h000003, seen, err);
        @(negedge clk);
        run = 1'b1;
        wait_time_change(24'h000003, cur);
        wait_time_change(cur, cur);
        check_time(24'h000005, cur);
        @(negedge clk);
        check_bit(1'b0, alarm_flag);
        run = 1'b0;
    endtask

    task automatic test_display();
        time_bcd_t  value;
        time_bcd_t  seen;
        logic       err;
        digit_sel_t visited;
        bcd_t       digit;
        test_name = "display";
        value = from_seconds(int'($urandom % 86400));
        host_write(1'b0, value, seen, err);
        check_bit(1'b0, err);
        check_time(value, seen);
        visited = '0;
        repeat (NUM_DIGITS * SCAN_DIV) begin
            @(negedge clk);
            check_bit(1'b1, $onehot(digit_sel));
            digit = '0;
            for (int i = 0; i < NUM_DIGITS; i++) begin
                if (digit_sel == digit_sel_t'(1 << i)) begin
                    digit = bcd_t'(value >> (4 * i));
                end
            end
            check_seg(seg_pattern(digit), seg);
            visited = visited | digit_sel;
        end
        check_sel(6'b111111, visited);
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        #(2 * TEST_SECONDS * CLK_DIV * CLK_PERIOD);
        abort_run("Watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(32'hf5882888));
        rst_n     = 1'b0;
        run       = 1'b0;
        set_req   = 1'b0;
        set_sel   = 1'b0;
        set_data  = '0;
        alarm_en  = 1'b0;
        alarm_clr = 1'b0;
        test_name = "init";
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_counting();
        test_rollover();
        test_set_port();
        test_alarm();
        test_display();
        $display("TEST PASSED");
        $finish;
    end

endmodule : rtc_tb

`default_nettype wire

// File: tb.f
hw/rtc_pkg.sv
hw/rtc_tick_gen.sv
hw/rtc_time_counter.sv
hw/rtc_set_port.sv
hw/rtc_alarm.sv
hw/rtc_display_scan.sv
hw/rtc_top.sv
verification/rtc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the RTC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module rtc_tb -o rtc_sim \
    && ./obj_dir/rtc_sim \
    || { echo "Simulation failed"; exit 1; }
